//--- ppwm.f
ppwm_pkg.sv
pwm_regs.sv
pwm_bank.sv
pwm_readback.sv
ppwm.sv
tb_ppwm.sv

//--- ppwm.sv
`timescale 1ns/1ps

module ppwm (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cs,
  input  logic                 rd,
  input  logic                 wr,
  input  ppwm_pkg::addr_t      addr,
  input  ppwm_pkg::data_t      d_in,
  output ppwm_pkg::data_t      d_out,
  output ppwm_pkg::chan_bits_t pwm
);

  ppwm_pkg::chan_bits_t enable;
  ppwm_pkg::chan_bits_t start; // Restart pulse per channel
  ppwm_pkg::data_t      period [ppwm_pkg::num_channels];
  ppwm_pkg::data_t      duty [ppwm_pkg::num_channels];

  // Bus writes into the channel registers
  pwm_regs regs_i (
    .clk    (clk),
    .reset  (reset),
    .cs     (cs),
    .wr     (wr),
    .addr   (addr),
    .d_in   (d_in),
    .enable (enable),
    .period (period),
    .duty   (duty),
    .start  (start)
  );

  pwm_bank bank_i (
    .clk    (clk),
    .reset  (reset),
    .enable (enable),
    .start  (start),
    .period (period),
    .duty   (duty),
    .pwm    (pwm)
  );

  // Register and pin status reads
  pwm_readback readback_i (
    .clk    (clk),
    .reset  (reset),
    .cs     (cs),
    .rd     (rd),
    .wr     (wr),
    .addr   (addr),
    .enable (enable),
    .period (period),
    .duty   (duty),
    .pwm    (pwm),
    .d_out  (d_out)
  );

endmodule

//--- ppwm_pkg.sv
package ppwm_pkg;

  // Channel count of the peripheral
  localparam int num_channels = 8;

  // 32-bit bus word, also used for periods, duties and counters
  typedef logic [31:0] data_t;

  // Byte address on the peripheral bus
  typedef logic [7:0] addr_t;

  // One bit per channel, used for enables, start pulses and pins
  typedef logic [num_channels-1:0] chan_bits_t;

  // Each channel owns a group of three word registers
  localparam addr_t chan_stride = 8'd12; // Bytes between register groups

  localparam addr_t off_enable = 8'd0; // Enable, only bit 0 stored
  localparam addr_t off_period = 8'd4; // Period in clk cycles
  localparam addr_t off_duty = 8'd8; // High cycles per period

  // First byte past the last channel group
  localparam addr_t map_size = addr_t'(num_channels) * chan_stride;

  // Live pin levels, bit c is channel c
  localparam addr_t status_addr = 8'h60;

endpackage

//--- pwm_bank.sv
`timescale 1ns/1ps

module pwm_bank (
  input  logic                 clk,
  input  logic                 reset,
  input  ppwm_pkg::chan_bits_t enable,
  input  ppwm_pkg::chan_bits_t start,
  input  ppwm_pkg::data_t      period [ppwm_pkg::num_channels],
  input  ppwm_pkg::data_t      duty [ppwm_pkg::num_channels],
  output ppwm_pkg::chan_bits_t pwm
);

  for (genvar c = 0; c < ppwm_pkg::num_channels; c++) begin : g_chan
    ppwm_pkg::data_t cnt; // Position inside the current period
    logic            run; // Channel enabled with a usable period
    logic            pin_q;

    assign run = enable[c] && (period[c] != '0);

    always_ff @(posedge clk) begin
      if (reset) begin
        cnt <= '0;
      end else if (start[c] || !run) begin
        cnt <= '0; // Restart or idle
      end else if (cnt >= period[c] - 1) begin
        cnt <= '0; // Wrap, also after a shorter period is written
      end else begin
        cnt <= cnt + 1;
      end
    end

    // Pin lags the counter by one cycle
    always_ff @(posedge clk) begin
      if (reset) begin
        pin_q <= 1'b0;
      end else begin
        pin_q <= run && (cnt < duty[c]);
      end
    end

    assign pwm[c] = pin_q;

    // Turning a channel off drops its pin at the next edge
    a_off_low : assert property (
      @(posedge clk) disable iff (reset)
      !enable[c] |=> !pwm[c]
    );

    // Counter never reaches the period once the period has settled
    a_cnt_range : assert property (
      @(posedge clk) disable iff (reset)
      run && $stable(period[c]) |-> cnt < period[c]
    );
  end

endmodule

//--- pwm_readback.sv
`timescale 1ns/1ps

module pwm_readback (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cs,
  input  logic                 rd,
  input  logic                 wr,
  input  ppwm_pkg::addr_t      addr,
  input  ppwm_pkg::chan_bits_t enable,
  input  ppwm_pkg::data_t      period [ppwm_pkg::num_channels],
  input  ppwm_pkg::data_t      duty [ppwm_pkg::num_channels],
  input  ppwm_pkg::chan_bits_t pwm,
  output ppwm_pkg::data_t      d_out
);

  ppwm_pkg::addr_t rd_chan;
  ppwm_pkg::addr_t rd_off;
  ppwm_pkg::data_t rd_val; // Value of the addressed location

  assign rd_chan = addr / ppwm_pkg::chan_stride;
  assign rd_off = addr % ppwm_pkg::chan_stride;

  always_comb begin
    rd_val = '0; // Unmapped reads give zero
    if (addr == ppwm_pkg::status_addr) begin
      rd_val = ppwm_pkg::data_t'(pwm);
    end else if (addr < ppwm_pkg::map_size) begin
      for (int c = 0; c < ppwm_pkg::num_channels; c++) begin
        if (rd_chan == ppwm_pkg::addr_t'(c)) begin
          case (rd_off)
            ppwm_pkg::off_enable: rd_val = ppwm_pkg::data_t'(enable[c]);
            ppwm_pkg::off_period: rd_val = period[c];
            ppwm_pkg::off_duty: rd_val = duty[c];
            default: rd_val = '0; // Misaligned offset
          endcase
        end
      end
    end
  end

  // Read data is valid for the single cycle after the request
  always_ff @(posedge clk) begin
    if (reset) begin
      d_out <= '0;
    end else begin
      d_out <= (cs && rd) ? rd_val : '0;
    end
  end

  // Bus master never issues a read and a write together
  a_no_rd_wr : assert property (
    @(posedge clk) disable iff (reset)
    cs |-> !(rd && wr)
  );

endmodule

//--- pwm_regs.sv
`timescale 1ns/1ps

module pwm_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cs,
  input  logic                 wr,
  input  ppwm_pkg::addr_t      addr,
  input  ppwm_pkg::data_t      d_in,
  output ppwm_pkg::chan_bits_t enable,
  output ppwm_pkg::data_t      period [ppwm_pkg::num_channels],
  output ppwm_pkg::data_t      duty [ppwm_pkg::num_channels],
  output ppwm_pkg::chan_bits_t start
);

  ppwm_pkg::addr_t      wr_chan; // Channel index of the write
  ppwm_pkg::addr_t      wr_off; // Byte offset inside the group
  logic                 wr_hit; // Write lands inside the channel map
  ppwm_pkg::chan_bits_t sel_enable;
  ppwm_pkg::chan_bits_t sel_period;
  ppwm_pkg::chan_bits_t sel_duty;

  assign wr_chan = addr / ppwm_pkg::chan_stride;
  assign wr_off = addr % ppwm_pkg::chan_stride;
  assign wr_hit = cs && wr && (addr < ppwm_pkg::map_size);

  // Per channel write strobes; offsets not on a word boundary select nothing
  always_comb begin
    sel_enable = '0;
    sel_period = '0;
    sel_duty = '0;
    for (int c = 0; c < ppwm_pkg::num_channels; c++) begin
      if (wr_hit && (wr_chan == ppwm_pkg::addr_t'(c))) begin
        sel_enable[c] = (wr_off == ppwm_pkg::off_enable);
        sel_period[c] = (wr_off == ppwm_pkg::off_period);
        sel_duty[c] = (wr_off == ppwm_pkg::off_duty);
      end
    end
  end

  // Enable bits and the restart pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      enable <= '0;
      start <= '0;
    end else begin
      for (int c = 0; c < ppwm_pkg::num_channels; c++) begin
        start[c] <= sel_enable[c] && d_in[0] && !enable[c]; // Rising enable only
        if (sel_enable[c]) begin
          enable[c] <= d_in[0];
        end
      end
    end
  end

  // Period and duty words
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int c = 0; c < ppwm_pkg::num_channels; c++) begin
        period[c] <= '0;
        duty[c] <= '0;
      end
    end else begin
      for (int c = 0; c < ppwm_pkg::num_channels; c++) begin
        if (sel_period[c]) begin
          period[c] <= d_in;
        end
        if (sel_duty[c]) begin
          duty[c] <= d_in;
        end
      end
    end
  end

  // A start pulse marks exactly the cycle in which a channel turned on
  for (genvar c = 0; c < ppwm_pkg::num_channels; c++) begin : g_chk
    a_start_on_rise : assert property (
      @(posedge clk) disable iff (reset)
      start[c] |-> enable[c] && !$past(enable[c])
    );
  end

endmodule

//--- run.sh
#!/bin/sh
# Build the ppwm testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ppwm -f ppwm.f -o sim_ppwm \
  && ./obj_dir/sim_ppwm > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "FAIL: build or simulation error"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"
exit 0

//--- tb_ppwm.sv
`timescale 1ns/1ps

module tb_ppwm;

  localparam int num_rows = 8;
  localparam int max_wait = 2000; // Cycle limit for any single wait

  logic                 clk;
  logic                 reset;
  logic                 cs;
  logic                 rd;
  logic                 wr;
  ppwm_pkg::addr_t      addr;
  ppwm_pkg::data_t      d_in;
  ppwm_pkg::data_t      d_out;
  ppwm_pkg::chan_bits_t pwm;

  // Register contents expected after the writes so far
  logic            exp_enable [ppwm_pkg::num_channels];
  ppwm_pkg::data_t exp_period [ppwm_pkg::num_channels];
  ppwm_pkg::data_t exp_duty [ppwm_pkg::num_channels];

  int test_fails; // Failed checks in the running test
  int tests_passed;
  int tests_failed;

  // Duty table, one test per row
  string row_name [num_rows] = '{"duty_quarter", "duty_half", "duty_odd", "duty_zero",
                                 "duty_full", "duty_over", "period_zero", "duty_one"};
  int              row_chan [num_rows] = '{0, 1, 2, 3, 4, 5, 6, 7};
  ppwm_pkg::data_t row_period [num_rows] = '{8, 10, 7, 6, 5, 4, 0, 3};
  ppwm_pkg::data_t row_duty [num_rows] = '{2, 5, 3, 0, 5, 9, 3, 1};
  int              row_win [num_rows] = '{3, 2, 4, 3, 3, 4, 10, 5}; // In whole periods

  ppwm_pkg::addr_t unmapped [4] = '{8'h05, 8'h61, 8'h64, 8'hff};

  ppwm ppwm_i (
    .clk   (clk),
    .reset (reset),
    .cs    (cs),
    .rd    (rd),
    .wr    (wr),
    .addr  (addr),
    .d_in  (d_in),
    .d_out (d_out),
    .pwm   (pwm)
  );

  always #5 clk = ~clk;

  task automatic abort_run(string what);
    $display("Timeout while %s, no progress within %0d cycles", what, max_wait);
    $display("tests failed");
    $finish;
  endtask

  task automatic wait_cycles(int n, string what);
    int waited;
    waited = 0;
    while (waited < n) begin
      if (waited >= max_wait) begin
        abort_run(what);
      end
      @(posedge clk);
      waited++;
    end
  endtask

  task automatic check_value(string name, ppwm_pkg::data_t expected, ppwm_pkg::data_t actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED %s: expected 0x%08h actual 0x%08h", name, expected, actual);
      test_fails++;
    end
  endtask

  task automatic begin_test();
    test_fails = 0;
  endtask

  task automatic end_test(string name);
    if (test_fails == 0) begin
      $display("test %s: PASS", name);
      tests_passed++;
    end else begin
      $display("test %s: FAIL with %0d bad checks", name, test_fails);
      tests_failed++;
    end
  endtask

  task automatic bus_write(ppwm_pkg::addr_t a, ppwm_pkg::data_t value);
    @(posedge clk);
    cs <= 1'b1;
    wr <= 1'b1;
    addr <= a;
    d_in <= value;
    @(posedge clk); // Write sampled here
    cs <= 1'b0;
    wr <= 1'b0;
  endtask

  task automatic bus_read(ppwm_pkg::addr_t a, output ppwm_pkg::data_t value);
    @(posedge clk);
    cs <= 1'b1;
    rd <= 1'b1;
    addr <= a;
    @(posedge clk); // Request sampled, d_out loads on this edge
    cs <= 1'b0;
    rd <= 1'b0;
    @(negedge clk);
    value = d_out;
  endtask

  function automatic ppwm_pkg::addr_t reg_addr(int c, ppwm_pkg::addr_t off);
    return ppwm_pkg::addr_t'(c) * ppwm_pkg::chan_stride + off;
  endfunction

  task automatic set_enable(int c, ppwm_pkg::data_t value);
    bus_write(reg_addr(c, ppwm_pkg::off_enable), value);
    exp_enable[c] = value[0]; // Only bit 0 is kept
  endtask

  // Duty and period first, so the channel starts on its final settings
  task automatic set_channel(int c, ppwm_pkg::data_t en, ppwm_pkg::data_t per,
                             ppwm_pkg::data_t dty);
    bus_write(reg_addr(c, ppwm_pkg::off_duty), dty);
    exp_duty[c] = dty;
    bus_write(reg_addr(c, ppwm_pkg::off_period), per);
    exp_period[c] = per;
    set_enable(c, en);
  endtask

  task automatic verify_all(string name);
    ppwm_pkg::data_t v;
    for (int c = 0; c < ppwm_pkg::num_channels; c++) begin
      bus_read(reg_addr(c, ppwm_pkg::off_enable), v);
      check_value(name, ppwm_pkg::data_t'(exp_enable[c]), v);
      bus_read(reg_addr(c, ppwm_pkg::off_period), v);
      check_value(name, exp_period[c], v);
      bus_read(reg_addr(c, ppwm_pkg::off_duty), v);
      check_value(name, exp_duty[c], v);
    end
  endtask

  task automatic count_high(int c, int len, output int highs);
    int cycles;
    highs = 0;
    cycles = 0;
    while (cycles < len) begin
      if (cycles >= max_wait) begin
        abort_run("counting pin high cycles");
      end
      @(negedge clk);
      if (pwm[c]) begin
        highs++;
      end
      cycles++;
    end
  endtask

  // High cycles over a window, straight from the pin rule
  function automatic int expected_highs(ppwm_pkg::data_t per, ppwm_pkg::data_t dty, int win);
    if (per == 0 || dty == 0) begin
      return 0;
    end
    if (dty >= per) begin
      return win * int'(per);
    end
    return win * int'(dty);
  endfunction

  function automatic int window_len(int r);
    return (row_period[r] == 0) ? row_win[r] : row_win[r] * int'(row_period[r]);
  endfunction

  initial begin
    ppwm_pkg::data_t      v;
    ppwm_pkg::chan_bits_t pattern;
    int                   highs;
    int                   r;
    void'($urandom(32'hbf01));
    clk = 1'b0;
    reset = 1'b1;
    cs = 1'b0;
    rd = 1'b0;
    wr = 1'b0;
    addr = '0;
    d_in = '0;
    tests_passed = 0;
    tests_failed = 0;
    for (int c = 0; c < ppwm_pkg::num_channels; c++) begin
      exp_enable[c] = 1'b0;
      exp_period[c] = '0;
      exp_duty[c] = '0;
    end
    wait_cycles(5, "holding reset");
    reset <= 1'b0;

    begin_test();
    @(negedge clk);
    check_value("reset_state", '0, ppwm_pkg::data_t'(pwm));
    verify_all("reset_state");
    bus_read(ppwm_pkg::status_addr, v);
    check_value("reset_state", '0, v);
    end_test("reset_state");

    begin_test();
    for (int c = 0; c < ppwm_pkg::num_channels; c++) begin
      set_channel(c, $urandom, $urandom, $urandom);
    end
    verify_all("reg_readback");
    for (int c = 0; c < ppwm_pkg::num_channels; c++) begin
      set_enable(c, '0);
    end
    end_test("reg_readback");

    // Channels stay on after their row, later tests rely on that
    for (r = 0; r < num_rows; r++) begin
      begin_test();
      set_channel(row_chan[r], 32'd1, row_period[r], row_duty[r]);
      wait_cycles(int'(row_period[r]) + 3, "settling a channel");
      count_high(row_chan[r], window_len(r), highs);
      check_value(row_name[r], ppwm_pkg::data_t'(expected_highs(row_period[r], row_duty[r],
                  row_win[r])), ppwm_pkg::data_t'(highs));
      end_test(row_name[r]);
    end

    begin_test();
    set_enable(row_chan[1], '0);
    wait_cycles(2, "waiting after disable");
    count_high(row_chan[1], int'(row_period[1]), highs);
    check_value("disable", '0, ppwm_pkg::data_t'(highs));
    count_high(row_chan[4], window_len(4), highs); // Full duty neighbour
    check_value("disable", ppwm_pkg::data_t'(window_len(4)), ppwm_pkg::data_t'(highs));
    count_high(row_chan[0], window_len(0), highs);
    check_value("disable", ppwm_pkg::data_t'(expected_highs(row_period[0], row_duty[0],
                row_win[0])), ppwm_pkg::data_t'(highs));
    end_test("disable");

    begin_test();
    for (int i = 0; i < 4; i++) begin
      bus_read(unmapped[i], v);
      check_value("unmapped", '0, v);
    end
    for (int i = 0; i < 4; i++) begin
      bus_write(unmapped[i], '1);
    end
    bus_write(ppwm_pkg::status_addr, '1); // Status word is read only
    verify_all("unmapped");
    end_test("unmapped");

    begin_test();
    pattern = 8'b1001_0110;
    for (int c = 0; c < ppwm_pkg::num_channels; c++) begin
      set_channel(c, 32'd1, 32'd4, pattern[c] ? ppwm_pkg::data_t'(4 + c) : '0);
    end
    wait_cycles(4 + 3, "settling steady levels");
    bus_read(ppwm_pkg::status_addr, v);
    check_value("status_word", ppwm_pkg::data_t'(pattern), v);
    check_value("status_word", ppwm_pkg::data_t'(pattern), ppwm_pkg::data_t'(pwm));
    end_test("status_word");

    $display("summary: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
